//--- board_bus.f
+incdir+bench
verilog/soc_map_pkg.sv
verilog/bus_pkg.sv
verilog/bus_target_control.sv
verilog/local_ram.sv
verilog/plic_gateway.sv
verilog/plic_context.sv
verilog/bus_response.sv
verilog/board_bus.sv
bench/board_bus_tb.sv

//--- bench/board_bus_tasks.svh
`ifndef board_bus_tasks_svh
`define board_bus_tasks_svh

// register addresses from the memory map
function automatic bus_pkg::addr_t ram_addr(input int index);
    return soc_map_pkg::ram_base + bus_pkg::addr_t'(4 * index);
endfunction

function automatic bus_pkg::addr_t prio_addr(input int id);
    return soc_map_pkg::plic_base + bus_pkg::addr_t'(4 * id);
endfunction

function automatic bus_pkg::addr_t pending_addr();
    return soc_map_pkg::plic_base + soc_map_pkg::plic_pending_off;
endfunction

function automatic bus_pkg::addr_t enable_addr(input int ctx);
    return soc_map_pkg::plic_base + soc_map_pkg::plic_enable_off
        + bus_pkg::addr_t'(ctx) * soc_map_pkg::plic_enable_stride;
endfunction

function automatic bus_pkg::addr_t threshold_addr(input int ctx);
    return soc_map_pkg::plic_base + soc_map_pkg::plic_threshold_off
        + bus_pkg::addr_t'(ctx) * soc_map_pkg::plic_ctx_stride;
endfunction

function automatic bus_pkg::addr_t claim_addr(input int ctx);
    return soc_map_pkg::plic_base + soc_map_pkg::plic_claim_off
        + bus_pkg::addr_t'(ctx) * soc_map_pkg::plic_ctx_stride;
endfunction

// expected 64-bit load of a value with the given width
function automatic bus_pkg::data_t extend_load(input logic [31:0] value, input int bits,
                                               input logic signed_load);
    bus_pkg::data_t result;
    result = '0;
    for (int i = 0; i < 64; i++) begin
        if (i < bits) begin
            result[i] = value[i];
        end else begin
            result[i] = signed_load & value[bits-1];
        end
    end
    return result;
endfunction

task automatic bus_write(input bus_pkg::addr_t addr, input bus_pkg::data_t wdata,
                         input bus_pkg::ls_type_e ls);
    @(posedge CLOCK_50);
    bus_req.addr <= addr;
    bus_req.wdata <= wdata;
    bus_req.ls_type <= ls;
    bus_req.write <= 1'b1;
    @(posedge CLOCK_50);
    bus_req.write <= 1'b0;
    // done drops, then comes back when the last step is through
    @(negedge CLOCK_50);
    while (bus_write_done) begin
        @(negedge CLOCK_50);
    end
    while (!bus_write_done) begin
        @(negedge CLOCK_50);
    end
endtask

task automatic bus_read(input bus_pkg::addr_t addr, input bus_pkg::ls_type_e ls,
                        output bus_pkg::data_t data);
    @(posedge CLOCK_50);
    bus_req.addr <= addr;
    bus_req.ls_type <= ls;
    bus_req.read <= 1'b1;
    @(posedge CLOCK_50);
    bus_req.read <= 1'b0;
    @(negedge CLOCK_50);
    while (bus_read_done) begin
        @(negedge CLOCK_50);
    end
    while (!bus_read_done) begin
        @(negedge CLOCK_50);
    end
    data = bus_read_data;
endtask

task automatic check_data(input string name, input bus_pkg::data_t got,
                          input bus_pkg::data_t exp);
    if (got !== exp) begin
        $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end_with_failure();
    end
endtask

task automatic check_irq(input logic [soc_map_pkg::num_contexts-1:0] got,
                         input logic [soc_map_pkg::num_contexts-1:0] exp);
    if (got !== exp) begin
        $display("** Error at %0t: ext_irq = %b, expected %b", $time, got, exp);
        end_with_failure();
    end
endtask

task automatic check_done(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end_with_failure();
    end
endtask

// the source synchronizer takes a few edges
task automatic wait_for_irq(input logic [soc_map_pkg::num_contexts-1:0] exp);
    int waited;
    waited = 0;
    @(negedge CLOCK_50);
    while (ext_irq !== exp && waited < 8) begin
        @(negedge CLOCK_50);
        waited++;
    end
    check_irq(ext_irq, exp);
endtask

task automatic test_ram_doubleword();
    int index;
    bus_pkg::data_t value;
    bus_pkg::data_t got;
    for (int k = 0; k < 4; k++) begin
        // even index keeps the doubleword aligned
        index = k * 512 + 2 * int'($urandom_range(0, 255));
        value = {$urandom, $urandom};
        value[31] = k[0];
        value[63] = ~k[0];
        bus_write(ram_addr(index), value, bus_pkg::ls_d);
        bus_read(ram_addr(index), bus_pkg::ls_d, got);
        check_data("bus_read_data", got, value);
        bus_read(ram_addr(index), bus_pkg::ls_w, got);
        check_data("bus_read_data", got, extend_load(value[31:0], 32, 1'b1));
        bus_read(ram_addr(index + 1), bus_pkg::ls_wu, got);
        check_data("bus_read_data", got, extend_load(value[63:32], 32, 1'b0));
        bus_read(ram_addr(index + 1), bus_pkg::ls_w, got);
        check_data("bus_read_data", got, extend_load(value[63:32], 32, 1'b1));
    end
    // plain word store drops the upper data half
    index = 2 * int'($urandom_range(0, 1023)) + 1;
    value = {$urandom, $urandom};
    value[31] = 1'b1;
    bus_write(ram_addr(index), value, bus_pkg::ls_w);
    bus_read(ram_addr(index), bus_pkg::ls_w, got);
    check_data("bus_read_data", got, extend_load(value[31:0], 32, 1'b1));
    bus_read(ram_addr(index), bus_pkg::ls_wu, got);
    check_data("bus_read_data", got, extend_load(value[31:0], 32, 1'b0));
endtask

task automatic test_ram_subword();
    int index;
    bus_pkg::word_t model;
    bus_pkg::data_t wdata;
    bus_pkg::data_t got;
    bus_pkg::addr_t addr;
    index = int'($urandom_range(0, soc_map_pkg::ram_words - 1));
    model = $urandom;
    bus_write(ram_addr(index), bus_pkg::data_t'(model), bus_pkg::ls_w);
    for (int off = 0; off < 4; off++) begin
        addr = ram_addr(index) + bus_pkg::addr_t'(off);
        // junk above the byte must not reach memory
        wdata = {$urandom, $urandom};
        wdata[7] = off[0];
        bus_write(addr, wdata, bus_pkg::ls_b);
        model[8*off +: 8] = wdata[7:0];
        bus_read(addr, bus_pkg::ls_b, got);
        check_data("bus_read_data", got, extend_load(32'(wdata[7:0]), 8, 1'b1));
        bus_read(addr, bus_pkg::ls_bu, got);
        check_data("bus_read_data", got, extend_load(32'(wdata[7:0]), 8, 1'b0));
        bus_read(ram_addr(index), bus_pkg::ls_wu, got);
        check_data("bus_read_data", got, extend_load(model, 32, 1'b0));
    end
    for (int off = 0; off < 4; off += 2) begin
        addr = ram_addr(index) + bus_pkg::addr_t'(off);
        wdata = {$urandom, $urandom};
        wdata[15] = off[1];
        bus_write(addr, wdata, bus_pkg::ls_h);
        model[8*off +: 16] = wdata[15:0];
        bus_read(addr, bus_pkg::ls_h, got);
        check_data("bus_read_data", got, extend_load(32'(wdata[15:0]), 16, 1'b1));
        bus_read(addr, bus_pkg::ls_hu, got);
        check_data("bus_read_data", got, extend_load(32'(wdata[15:0]), 16, 1'b0));
        bus_read(ram_addr(index), bus_pkg::ls_w, got);
        check_data("bus_read_data", got, extend_load(model, 32, 1'b1));
    end
endtask

task automatic test_register_readback();
    bus_pkg::data_t prio_val [soc_map_pkg::num_sources];
    bus_pkg::data_t en_val [soc_map_pkg::num_contexts];
    bus_pkg::data_t th_val [soc_map_pkg::num_contexts];
    bus_pkg::data_t got;
    for (int id = 1; id < soc_map_pkg::num_sources; id++) begin
        prio_val[id] = {$urandom, $urandom};
        bus_write(prio_addr(id), prio_val[id], bus_pkg::ls_w);
    end
    for (int id = 1; id < soc_map_pkg::num_sources; id++) begin
        bus_read(prio_addr(id), bus_pkg::ls_wu, got);
        check_data("bus_read_data", got, prio_val[id] & 64'h7);
    end
    // context 1 first so the context 0 writes land afterwards
    for (int c = soc_map_pkg::num_contexts - 1; c >= 0; c--) begin
        en_val[c] = {$urandom, $urandom};
        th_val[c] = {$urandom, $urandom};
        bus_write(enable_addr(c), en_val[c], bus_pkg::ls_w);
        bus_write(threshold_addr(c), th_val[c], bus_pkg::ls_w);
    end
    for (int c = soc_map_pkg::num_contexts - 1; c >= 0; c--) begin
        bus_read(enable_addr(c), bus_pkg::ls_wu, got);
        check_data("bus_read_data", got, en_val[c] & 64'h3f);
        bus_read(threshold_addr(c), bus_pkg::ls_wu, got);
        check_data("bus_read_data", got, th_val[c] & 64'h7);
    end
endtask

task automatic test_interrupt_path();
    bus_pkg::data_t got;
    // context 0 takes ids 3 and 5 and context 1 only id 5
    bus_write(enable_addr(0), 64'b10_1000, bus_pkg::ls_w);
    bus_write(enable_addr(1), 64'b10_0000, bus_pkg::ls_w);
    check_irq(ext_irq, 2'b00);
    @(posedge CLOCK_50);
    irq_src[3] <= 1'b1;
    wait_for_irq(2'b01);
    bus_read(pending_addr(), bus_pkg::ls_wu, got);
    check_data("bus_read_data", got, 64'b00_1000);
    // id 1 pends but nobody enables it
    @(posedge CLOCK_50);
    irq_src[5] <= 1'b1;
    irq_src[1] <= 1'b1;
    wait_for_irq(2'b11);
    bus_read(pending_addr(), bus_pkg::ls_wu, got);
    check_data("bus_read_data", got, 64'b10_1010);
    bus_read(claim_addr(0), bus_pkg::ls_wu, got);
    check_data("bus_read_data", got, 64'd3);
    check_irq(ext_irq, 2'b11);
    bus_read(pending_addr(), bus_pkg::ls_wu, got);
    check_data("bus_read_data", got, 64'b10_0010);
    bus_read(claim_addr(1), bus_pkg::ls_wu, got);
    check_data("bus_read_data", got, 64'd5);
    check_irq(ext_irq, 2'b00);
    bus_read(claim_addr(0), bus_pkg::ls_wu, got);
    check_data("bus_read_data", got, 64'd0);
    bus_read(pending_addr(), bus_pkg::ls_wu, got);
    check_data("bus_read_data", got, 64'b00_0010);
    @(posedge CLOCK_50);
    irq_src <= '0;
endtask

task automatic test_reset_and_unmapped();
    bus_pkg::data_t value;
    bus_pkg::data_t got;
    value = {$urandom, $urandom} | 64'h1;
    bus_write(ram_addr(6), value, bus_pkg::ls_d);
    bus_read(ram_addr(6), bus_pkg::ls_d, got);
    check_data("bus_read_data", got, value);
    // id 1 is still pending, so both lines go high before the reset
    bus_write(enable_addr(0), 64'b00_0010, bus_pkg::ls_w);
    bus_write(enable_addr(1), 64'b00_0010, bus_pkg::ls_w);
    check_irq(ext_irq, 2'b11);
    apply_reset();
    @(negedge CLOCK_50);
    check_done("bus_read_done", bus_read_done, 1'b1);
    check_done("bus_write_done", bus_write_done, 1'b1);
    check_irq(ext_irq, 2'b00);
    check_data("bus_read_data", bus_read_data, 64'd0);
    bus_read(pending_addr(), bus_pkg::ls_wu, got);
    check_data("bus_read_data", got, 64'd0);
    bus_read(enable_addr(0), bus_pkg::ls_wu, got);
    check_data("bus_read_data", got, 64'd0);
    // nonzero read data first, so a zero from the hole means something
    bus_write(ram_addr(6), value, bus_pkg::ls_d);
    bus_read(ram_addr(6), bus_pkg::ls_d, got);
    check_data("bus_read_data", got, value);
    bus_write(64'h0000_0000_4000_0000, value, bus_pkg::ls_d);
    bus_read(64'h0000_0000_4000_0000, bus_pkg::ls_d, got);
    check_data("bus_read_data", got, 64'd0);
    bus_read(ram_addr(6), bus_pkg::ls_d, got);
    check_data("bus_read_data", got, value);
    bus_read(soc_map_pkg::plic_base + 64'h100, bus_pkg::ls_w, got);
    check_data("bus_read_data", got, 64'd0);
endtask

`endif

//--- bench/board_bus_tb.sv
`timescale 1ns/1ps

module board_bus_tb;

    // about 90 bus accesses of 4 to 5 cycles each, plus two resets and
    // the interrupt waits, stay well under this
    localparam int max_cycles = 2000;

    logic CLOCK_50;
    logic KEY0;
    bus_pkg::bus_req_t bus_req;
    logic [soc_map_pkg::num_sources-1:1] irq_src;
    bus_pkg::data_t bus_read_data;
    logic bus_read_done;
    logic bus_write_done;
    logic [soc_map_pkg::num_contexts-1:0] ext_irq;

    int cycle_count = 0;

    board_bus board_bus_inst (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .bus_req        (bus_req),
        .irq_src        (irq_src),
        .bus_read_data  (bus_read_data),
        .bus_read_done  (bus_read_done),
        .bus_write_done (bus_write_done),
        .ext_irq        (ext_irq)
    );

    `include "board_bus_tasks.svh"

    // 4 ns period
    always #2 CLOCK_50 = ~CLOCK_50;

    task automatic end_with_failure();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // reset held low for five rising edges
    task automatic apply_reset();
        @(posedge CLOCK_50);
        KEY0 <= 1'b0;
        repeat (5) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
    endtask

    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            end_with_failure();
        end
    end

    initial begin
        void'($urandom(32'h38010336));
        CLOCK_50 = 1'b0;
        KEY0 = 1'b0;
        bus_req = '0;
        irq_src = '0;

        apply_reset();

        test_ram_doubleword();
        test_ram_subword();
        test_register_readback();
        test_interrupt_path();
        test_reset_and_unmapped();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- verilog/board_bus.sv
`timescale 1ns/1ps

module board_bus (
    input  logic                                    CLOCK_50,
    input  logic                                    KEY0,
    input  bus_pkg::bus_req_t                       bus_req,
    input  logic [soc_map_pkg::num_sources-1:1]     irq_src,
    output bus_pkg::data_t                          bus_read_data,
    output logic                                    bus_read_done,
    output logic                                    bus_write_done,
    output logic [soc_map_pkg::num_contexts-1:0]    ext_irq
);

    bus_pkg::access_t access;
    bus_pkg::word_t ram_rdata;
    soc_map_pkg::priority_t prio_rdata;
    soc_map_pkg::source_mask_t pending;

    // per-context state, indexed by context number
    soc_map_pkg::source_mask_t [soc_map_pkg::num_contexts-1:0] enable;
    soc_map_pkg::priority_t [soc_map_pkg::num_contexts-1:0] threshold;
    soc_map_pkg::source_id_t [soc_map_pkg::num_contexts-1:0] claim_id;

    bus_target_control bus_target_control_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus_req  (bus_req),
        .access   (access)
    );

    local_ram local_ram_inst (
        .CLOCK_50  (CLOCK_50),
        .access    (access),
        .ram_rdata (ram_rdata)
    );

    plic_gateway plic_gateway_inst (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .access     (access),
        .irq_src    (irq_src),
        .claim_id   (claim_id),
        .pending    (pending),
        .prio_rdata (prio_rdata)
    );

    generate
        for (genvar c = 0; c < soc_map_pkg::num_contexts; c++) begin : g_ctx
            plic_context #(
                .ctx_num (c)
            ) plic_context_inst (
                .CLOCK_50  (CLOCK_50),
                .KEY0      (KEY0),
                .access    (access),
                .pending   (pending),
                .enable    (enable[c]),
                .threshold (threshold[c]),
                .claim_id  (claim_id[c]),
                .irq       (ext_irq[c])
            );
        end
    endgenerate

    bus_response bus_response_inst (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .access         (access),
        .ram_rdata      (ram_rdata),
        .prio_rdata     (prio_rdata),
        .pending        (pending),
        .enable         (enable),
        .threshold      (threshold),
        .claim_id       (claim_id),
        .bus_read_data  (bus_read_data),
        .bus_read_done  (bus_read_done),
        .bus_write_done (bus_write_done)
    );

endmodule

//--- verilog/bus_response.sv
`timescale 1ns/1ps

module bus_response (
    input  logic                      CLOCK_50,
    input  logic                      KEY0,
    input  bus_pkg::access_t          access,
    input  bus_pkg::word_t            ram_rdata,
    input  soc_map_pkg::priority_t    prio_rdata,
    input  soc_map_pkg::source_mask_t pending,
    input  soc_map_pkg::source_mask_t [soc_map_pkg::num_contexts-1:0] enable,
    input  soc_map_pkg::priority_t [soc_map_pkg::num_contexts-1:0] threshold,
    input  soc_map_pkg::source_id_t [soc_map_pkg::num_contexts-1:0] claim_id,
    output bus_pkg::data_t            bus_read_data,
    output logic                      bus_read_done,
    output logic                      bus_write_done
);

    // step info held for the edge after the step
    logic step_q;
    logic last_q;
    logic high_q;
    logic write_q;
    bus_pkg::target_e target_q;
    bus_pkg::ls_type_e ls_q;
    logic [1:0] off_q;
    bus_pkg::word_t reg_word_q;
    bus_pkg::word_t low_q;

    bus_pkg::word_t reg_word;
    bus_pkg::word_t rd_word;
    bus_pkg::word_t shifted;
    bus_pkg::data_t load_data;

    // register-side value, sampled at the end of the step before a claim clears it
    always_comb begin
        case (access.target)
            bus_pkg::tgt_prio: reg_word = bus_pkg::word_t'(prio_rdata);
            bus_pkg::tgt_pending: reg_word = bus_pkg::word_t'(pending);
            bus_pkg::tgt_enable: reg_word = bus_pkg::word_t'(enable[access.ctx]);
            bus_pkg::tgt_threshold: reg_word = bus_pkg::word_t'(threshold[access.ctx]);
            bus_pkg::tgt_claim: reg_word = bus_pkg::word_t'(claim_id[access.ctx]);
            default: reg_word = '0;
        endcase
    end

    assign rd_word = (target_q == bus_pkg::tgt_ram) ? ram_rdata : reg_word_q;
    assign shifted = rd_word >> {off_q, 3'b000};

    always_comb begin
        case (ls_q)
            bus_pkg::ls_b: load_data = {{56{shifted[7]}}, shifted[7:0]};
            bus_pkg::ls_bu: load_data = {56'd0, shifted[7:0]};
            bus_pkg::ls_h: load_data = {{48{shifted[15]}}, shifted[15:0]};
            bus_pkg::ls_hu: load_data = {48'd0, shifted[15:0]};
            bus_pkg::ls_w: load_data = {{32{rd_word[31]}}, rd_word};
            bus_pkg::ls_d: load_data = high_q ? {rd_word, low_q} : {32'd0, rd_word};
            default: load_data = {32'd0, rd_word};
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (access.valid) begin
            last_q <= access.last;
            high_q <= access.high;
            write_q <= access.is_write;
            target_q <= access.target;
            ls_q <= access.ls_type;
            off_q <= access.offset;
            reg_word_q <= reg_word;
        end
        // lower word of a doubleword waits for the upper one
        if (step_q && !last_q) begin
            low_q <= rd_word;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            step_q <= 1'b0;
            bus_read_done <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data <= '0;
        end else begin
            step_q <= access.valid;
            if (access.valid) begin
                if (access.is_write) begin
                    bus_write_done <= 1'b0;
                end else begin
                    bus_read_done <= 1'b0;
                end
            end
            if (step_q && last_q) begin
                if (write_q) begin
                    bus_write_done <= 1'b1;
                end else begin
                    bus_read_done <= 1'b1;
                    bus_read_data <= load_data;
                end
            end
        end
    end

endmodule

//--- verilog/plic_context.sv
`timescale 1ns/1ps

module plic_context #(
    parameter int ctx_num = 0
) (
    input  logic                      CLOCK_50,
    input  logic                      KEY0,
    input  bus_pkg::access_t          access,
    input  soc_map_pkg::source_mask_t pending,
    output soc_map_pkg::source_mask_t enable,
    output soc_map_pkg::priority_t    threshold,
    output soc_map_pkg::source_id_t   claim_id,
    output logic                      irq
);

    logic wr_sel;

    assign wr_sel = access.valid && access.is_write && (access.ctx == 1'(ctx_num));

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            enable <= '0;
            threshold <= '0;
        end else if (wr_sel) begin
            if (access.target == bus_pkg::tgt_enable) begin
                enable <= soc_map_pkg::source_mask_t'(access.wdata);
            end
            if (access.target == bus_pkg::tgt_threshold) begin
                threshold <= soc_map_pkg::priority_t'(access.wdata);
            end
        end
    end

    // walk down so the lowest pending and enabled id is left
    always_comb begin
        claim_id = '0;
        for (int i = soc_map_pkg::num_sources - 1; i >= 1; i--) begin
            if (pending[i] && enable[i]) begin
                claim_id = soc_map_pkg::source_id_t'(i);
            end
        end
    end

    assign irq = (claim_id != '0);

endmodule

//--- verilog/plic_gateway.sv
`timescale 1ns/1ps

module plic_gateway (
    input  logic                                   CLOCK_50,
    input  logic                                   KEY0,
    input  bus_pkg::access_t                       access,
    input  logic [soc_map_pkg::num_sources-1:1]    irq_src,
    input  soc_map_pkg::source_id_t [soc_map_pkg::num_contexts-1:0] claim_id,
    output soc_map_pkg::source_mask_t              pending,
    output soc_map_pkg::priority_t                 prio_rdata
);

    logic [soc_map_pkg::num_sources-1:1] src_meta;
    logic [soc_map_pkg::num_sources-1:1] src_sync;
    logic [soc_map_pkg::num_sources-1:1] src_prev;
    logic [soc_map_pkg::num_sources-1:1] src_rise;

    soc_map_pkg::priority_t prio [soc_map_pkg::num_sources];
    soc_map_pkg::source_mask_t clear_mask;
    logic claim_rd;
    logic prio_wr;

    assign src_rise = src_sync & ~src_prev;

    assign claim_rd = access.valid && !access.is_write && (access.target == bus_pkg::tgt_claim);
    assign prio_wr = access.valid && access.is_write && (access.target == bus_pkg::tgt_prio);

    // claimed id of the addressed context
    assign clear_mask = claim_rd ? soc_map_pkg::source_mask_t'(1) << claim_id[access.ctx] : '0;

    // decode keeps src inside the priority array
    assign prio_rdata = prio[access.src];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            src_meta <= '0;
            src_sync <= '0;
            src_prev <= '0;
            pending <= '0;
        end else begin
            src_meta <= irq_src;
            src_sync <= src_meta;
            src_prev <= src_sync;
            // a new edge wins over a claim of the same id
            pending <= (pending & ~clear_mask) | {src_rise, 1'b0};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < soc_map_pkg::num_sources; i++) begin
                prio[i] <= '0;
            end
        end else if (prio_wr && access.src != '0) begin
            prio[access.src] <= soc_map_pkg::priority_t'(access.wdata);
        end
    end

endmodule

//--- verilog/local_ram.sv
`timescale 1ns/1ps

module local_ram (
    input  logic             CLOCK_50,
    input  bus_pkg::access_t access,
    output bus_pkg::word_t   ram_rdata
);

    bus_pkg::word_t mem [soc_map_pkg::ram_words];

    logic [3:0] lanes;
    bus_pkg::word_t lane_data;
    logic wr_en;

    assign wr_en = access.valid && access.is_write && (access.target == bus_pkg::tgt_ram);

    // byte lanes and replicated store data for the sized store
    always_comb begin
        case (access.ls_type)
            bus_pkg::ls_b,
            bus_pkg::ls_bu: begin
                lanes = 4'b0001 << access.offset;
                lane_data = {4{access.wdata[7:0]}};
            end
            bus_pkg::ls_h,
            bus_pkg::ls_hu: begin
                // halves sit on even offsets only
                lanes = access.offset[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{access.wdata[15:0]}};
            end
            default: begin
                lanes = 4'b1111;
                lane_data = access.wdata;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (lanes[b]) begin
                    mem[access.index][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
    end

    // registered read, old word on a same-cycle store
    always_ff @(posedge CLOCK_50) begin
        ram_rdata <= mem[access.index];
    end

endmodule

//--- verilog/bus_target_control.sv
`timescale 1ns/1ps

module bus_target_control (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  bus_pkg::bus_req_t bus_req,
    output bus_pkg::access_t  access
);

    typedef enum logic [1:0] {
        idle,
        step_low,
        step_high
    } state_e;

    state_e state;
    bus_pkg::bus_req_t req_q;

    bus_pkg::addr_t ram_off;
    bus_pkg::addr_t plic_off;
    bus_pkg::target_e tgt;
    logic ctx;
    soc_map_pkg::source_id_t src;
    logic two_step;
    logic start;

    // strobes arriving while busy are dropped
    assign start = (state == idle) && (bus_req.read || bus_req.write);

    always_ff @(posedge CLOCK_50) begin
        if (start) begin
            req_q <= bus_req;
        end
    end

    // address decode from the held request
    always_comb begin
        ram_off = req_q.addr - soc_map_pkg::ram_base;
        plic_off = req_q.addr - soc_map_pkg::plic_base;
        tgt = bus_pkg::tgt_none;
        ctx = 1'b0;
        src = '0;
        if (ram_off < 64'(4 * soc_map_pkg::ram_words)) begin
            tgt = bus_pkg::tgt_ram;
        end else if (plic_off < 64'(4 * soc_map_pkg::num_sources) && plic_off[1:0] == 2'b00) begin
            tgt = bus_pkg::tgt_prio;
            src = plic_off[4:2];
        end else if (plic_off == soc_map_pkg::plic_pending_off) begin
            tgt = bus_pkg::tgt_pending;
        end else begin
            for (int c = 0; c < soc_map_pkg::num_contexts; c++) begin
                if (plic_off == soc_map_pkg::plic_enable_off
                        + 64'(c) * soc_map_pkg::plic_enable_stride) begin
                    tgt = bus_pkg::tgt_enable;
                    ctx = c[0];
                end
                if (plic_off == soc_map_pkg::plic_threshold_off
                        + 64'(c) * soc_map_pkg::plic_ctx_stride) begin
                    tgt = bus_pkg::tgt_threshold;
                    ctx = c[0];
                end
                if (plic_off == soc_map_pkg::plic_claim_off
                        + 64'(c) * soc_map_pkg::plic_ctx_stride) begin
                    tgt = bus_pkg::tgt_claim;
                    ctx = c[0];
                end
            end
        end
    end

    // only RAM doublewords need a second word
    assign two_step = (tgt == bus_pkg::tgt_ram) && (req_q.ls_type == bus_pkg::ls_d);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= step_low;
                    end
                end
                step_low: state <= two_step ? step_high : idle;
                default: state <= idle;
            endcase
        end
    end

    always_comb begin
        access.valid = (state != idle);
        access.is_write = req_q.write;
        access.target = tgt;
        access.ctx = ctx;
        access.src = src;
        access.index = ram_off[2 +: $bits(bus_pkg::ram_index_t)]
            + bus_pkg::ram_index_t'(state == step_high);
        access.offset = req_q.addr[1:0];
        access.ls_type = req_q.ls_type;
        // upper half of the write data goes with the second step
        access.wdata = (state == step_high) ? req_q.wdata[63:32] : req_q.wdata[31:0];
        access.last = (state == step_high) || !two_step;
        access.high = (state == step_high);
    end

endmodule

//--- verilog/bus_pkg.sv
package bus_pkg;

    localparam int data_w = 64;
    localparam int word_w = 32;

    typedef logic [data_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [word_w-1:0] word_t;
    typedef logic [$clog2(soc_map_pkg::ram_words)-1:0] ram_index_t;

    // load/store type as driven by the core
    typedef enum logic [2:0] {
        ls_b  = 3'd0,
        ls_h  = 3'd1,
        ls_w  = 3'd2,
        ls_d  = 3'd3,
        ls_bu = 3'd4,
        ls_hu = 3'd5,
        ls_wu = 3'd6
    } ls_type_e;

    typedef enum logic [2:0] {
        tgt_none,
        tgt_ram,
        tgt_prio,
        tgt_pending,
        tgt_enable,
        tgt_threshold,
        tgt_claim
    } target_e;

    typedef struct packed {
        addr_t    addr;
        data_t    wdata;
        ls_type_e ls_type;
        logic     read;
        logic     write;
    } bus_req_t;

    // one step of a decoded access, seen by every target
    typedef struct packed {
        logic                    valid;
        logic                    is_write;
        target_e                 target;
        logic                    ctx;
        soc_map_pkg::source_id_t src;
        ram_index_t              index;
        logic [1:0]              offset;
        ls_type_e                ls_type;
        word_t                   wdata;
        logic                    last;
        logic                    high;
    } access_t;

endpackage

//--- verilog/soc_map_pkg.sv
package soc_map_pkg;

    // on-chip RAM window
    localparam logic [63:0] ram_base = 64'h0000_0000_8000_0000;
    localparam int ram_words = 2048;

    // interrupt controller window
    localparam logic [63:0] plic_base = 64'h0000_0000_0C00_0000;

    // priority registers sit at the start of the window, 4 bytes per id
    localparam logic [63:0] plic_pending_off = 64'h0000_1000;
    localparam logic [63:0] plic_enable_off = 64'h0000_2000;
    localparam logic [63:0] plic_enable_stride = 64'h0000_0080;
    localparam logic [63:0] plic_threshold_off = 64'h0020_0000;
    localparam logic [63:0] plic_claim_off = 64'h0020_0004;

    // threshold and claim repeat per context at this distance
    localparam logic [63:0] plic_ctx_stride = 64'h0000_1000;

    // id 0 is reserved and never pends
    localparam int num_sources = 6;
    localparam int num_contexts = 2;

    typedef logic [2:0] source_id_t;
    typedef logic [2:0] priority_t;

    // one bit per id, bit 0 unused
    typedef logic [num_sources-1:0] source_mask_t;

endpackage
